//--- build.f
+incdir+design
design/axi_pkg.sv
design/sram_pkg.sv
design/lfsr8.sv
design/sram_array.sv
design/sram_read_channel.sv
design/sram_write_channel.sv
design/sram_top.sv
test/sram_properties.sv
test/sram_tb.sv

//--- Bender.yml
package:
  name: sram_axil

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/axi_pkg.sv
      - design/sram_pkg.sv
      - design/lfsr8.sv
      - design/sram_array.sv
      - design/sram_read_channel.sv
      - design/sram_write_channel.sv
      - design/sram_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/sram_properties.sv
      - test/sram_tb.sv

//--- test/sram_tb.sv
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_tb
  import axi_pkg::*, sram_pkg::*;
;

  localparam int DEPTH = 1 << `SRAM_IDX_W;
  localparam int OFF_W = $clog2(`SRAM_STRB_W);
  localparam int BYTE_W = `SRAM_DATA_W / `SRAM_STRB_W;
  // Preload, full words, strobes, orders, back-pressure, random mix.
  localparam int NUM_TXN = DEPTH + 8 + 14 + 6 + 8 + 200;
  localparam int LIMIT_CYCLES = NUM_TXN * (`SRAM_RD_MIN_LAT + 255 + 20) + 1000;

  typedef enum int {AW_FIRST, W_FIRST, BOTH} wr_order_e;

  logic    clk;
  logic    rstn;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_r_t  r;
  logic    r_valid;
  logic    r_ready;
  axi_aw_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_valid;
  logic    w_ready;
  axi_b_t  b;
  logic    b_valid;
  logic    b_ready;

  logic [7:0]              shadow [DEPTH*`SRAM_STRB_W];
  logic [`SRAM_DATA_W-1:0] rd_exp_q[$];
  string                   rd_name_q[$];
  string                   wr_name_q[$];
  int                      checks = 0;
  int                      errors = 0;

  sram_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Apply the strobed bytes to the shadow copy and return the whole word.
  function automatic logic [`SRAM_DATA_W-1:0] expected_word(
    input logic [`SRAM_IDX_W-1:0]  idx,
    input logic [`SRAM_DATA_W-1:0] data,
    input logic [`SRAM_STRB_W-1:0] strb
  );
    logic [`SRAM_DATA_W-1:0] word;
    int                      base;
    base = int'(idx) * `SRAM_STRB_W;
    for (int i = 0; i < `SRAM_STRB_W; i++) begin
      if (strb[i]) begin
        shadow[base+i] = data[i*BYTE_W +: BYTE_W];
      end
      word[i*BYTE_W +: BYTE_W] = shadow[base+i];
    end
    return word;
  endfunction

  function automatic logic [`SRAM_ADDR_W-1:0] word_addr(
    input logic [`SRAM_IDX_W-1:0]  idx,
    input logic [`SRAM_ADDR_W-1:0] upper
  );
    logic [`SRAM_ADDR_W-1:0] addr;
    addr = upper;
    addr[OFF_W +: `SRAM_IDX_W] = idx;
    return addr;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Callers sit on a falling edge.
  task automatic send_aw(input logic [`SRAM_ADDR_W-1:0] addr);
    aw.awaddr = addr;
    aw_valid = 1'b1;
    while (!aw_ready) @(negedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input logic [`SRAM_DATA_W-1:0] data,
                        input logic [`SRAM_STRB_W-1:0] strb);
    w.wdata = data;
    w.wstrb = strb;
    w_valid = 1'b1;
    while (!w_ready) @(negedge clk);
    @(negedge clk);
    w_valid = 1'b0;
  endtask

  task automatic axi_write(input string name, input logic [`SRAM_ADDR_W-1:0] addr,
                           input logic [`SRAM_DATA_W-1:0] data,
                           input logic [`SRAM_STRB_W-1:0] strb,
                           input wr_order_e order, input int delay);
    void'(expected_word(addr[OFF_W +: `SRAM_IDX_W], data, strb));
    wr_name_q.push_back(name);
    @(negedge clk);
    if (order == AW_FIRST) begin
      send_aw(addr);
      send_w(data, strb);
    end else if (order == W_FIRST) begin
      send_w(data, strb);
      send_aw(addr);
    end else begin
      aw.awaddr = addr;
      w.wdata = data;
      w.wstrb = strb;
      aw_valid = 1'b1;
      w_valid = 1'b1;
      while (!(aw_ready && w_ready)) @(negedge clk);
      @(negedge clk);
      aw_valid = 1'b0;
      w_valid = 1'b0;
    end
    while (!b_valid) @(negedge clk);
    repeat (delay) @(negedge clk);
    b_ready = 1'b1;
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic axi_read(input string name, input logic [`SRAM_ADDR_W-1:0] addr,
                          input int delay);
    rd_exp_q.push_back(expected_word(addr[OFF_W +: `SRAM_IDX_W], '0, '0));
    rd_name_q.push_back(name);
    @(negedge clk);
    ar.araddr = addr;
    ar_valid = 1'b1;
    while (!ar_ready) @(negedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    while (!r_valid) @(negedge clk);
    repeat (delay) @(negedge clk);
    r_ready = 1'b1;
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  // Responses are checked on the edge where the transfer happens.
  always @(posedge clk) begin
    if (!rstn && r_valid && r_ready) begin
      if (rd_exp_q.size() == 0) begin
        errors++;
        $display("Error: R transfer seen with no read outstanding");
      end else begin
        check_value({rd_name_q[0], " rdata"}, rd_exp_q[0], r.rdata);
        check_value({rd_name_q[0], " rresp"}, 32'(RESP_OKAY), 32'(r.rresp));
        void'(rd_exp_q.pop_front());
        void'(rd_name_q.pop_front());
      end
    end
    if (!rstn && b_valid && b_ready) begin
      if (wr_name_q.size() == 0) begin
        errors++;
        $display("Error: B transfer seen with no write outstanding");
      end else begin
        check_value({wr_name_q.pop_front(), " bresp"}, 32'(RESP_OKAY), 32'(b.bresp));
      end
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Test failures found");
    $finish;
  end

  initial begin
    logic [`SRAM_IDX_W-1:0]  idx;
    logic [`SRAM_DATA_W-1:0] data;
    logic [`SRAM_STRB_W-1:0] strb;
    logic [`SRAM_STRB_W-1:0] strobes [7];
    wr_order_e               order;
    int                      delay;
    void'($urandom(31));
    strobes = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b1010, 4'b0000};
    rstn = 1'b1;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;

    check_value("reset ar_ready", 1, ar_ready);
    check_value("reset aw_ready", 1, aw_ready);
    check_value("reset w_ready", 1, w_ready);
    check_value("reset r_valid", 0, r_valid);
    check_value("reset b_valid", 0, b_valid);

    // Preload every word so no read returns unknown contents.
    for (int i = 0; i < DEPTH; i++) begin
      idx = i[`SRAM_IDX_W-1:0];
      data = {idx, ~idx, idx ^ 8'h3c, idx + 8'd1};
      axi_write("preload", word_addr(idx, '0), data, '1, BOTH, 0);
    end

    for (int k = 0; k < 4; k++) begin
      idx = (k == 0) ? 8'd0 : (k == 3) ? 8'd255 : 8'(k * 77);
      axi_write($sformatf("full write %0d", idx), word_addr(idx, '0),
                32'hc0de_0000 | 32'(idx), '1, AW_FIRST, 0);
      axi_read($sformatf("full read %0d", idx), word_addr(idx, '0), 0);
    end

    foreach (strobes[k]) begin
      idx = 8'(16 + k);
      axi_write($sformatf("strobe %b write", strobes[k]), word_addr(idx, '0),
                32'ha55a_f00f ^ 32'(k), strobes[k], BOTH, 0);
      axi_read($sformatf("strobe %b read", strobes[k]), word_addr(idx, '0), 0);
    end

    for (int k = 0; k < 3; k++) begin
      order = wr_order_e'(k);
      idx = 8'(40 + k);
      axi_write($sformatf("order %s write", order.name()), word_addr(idx, '0),
                $urandom(), 4'b1111, order, 0);
      axi_read($sformatf("order %s read", order.name()), word_addr(idx, '0), 0);
    end

    for (int k = 0; k < 4; k++) begin
      idx = 8'(60 + k);
      delay = $urandom_range(12, 1);
      axi_write("backpressure write", word_addr(idx, '0), $urandom(), 4'b1111,
                W_FIRST, delay);
      delay = $urandom_range(12, 1);
      axi_read("backpressure read", word_addr(idx, '0), delay);
    end

    // Upper and lower address bits are random and must not matter.
    for (int n = 0; n < 200; n++) begin
      idx = 8'($urandom_range(DEPTH - 1, 0));
      delay = $urandom_range(8, 0);
      if ($urandom_range(1, 0) == 1) begin
        order = wr_order_e'($urandom_range(2, 0));
        strb = 4'($urandom_range(15, 0));
        axi_write("random write", word_addr(idx, $urandom()), $urandom(), strb, order, delay);
      end else begin
        axi_read("random read", word_addr(idx, $urandom()), delay);
      end
    end

    repeat (5) @(negedge clk);
    if (rd_exp_q.size() != 0 || wr_name_q.size() != 0) begin
      errors++;
      $display("Error: %0d reads and %0d writes never got a response",
               rd_exp_q.size(), wr_name_q.size());
    end
    $display("Checks: %0d, check errors: %0d, assertion errors: %0d",
             checks, errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- test/sram_properties.sv
`timescale 1ns/1ps

module sram_properties
  import axi_pkg::*, sram_pkg::*;
(
  input logic     clk,
  input logic     rstn,
  input axi_ar_t  ar,
  input logic     ar_valid,
  input logic     ar_ready,
  input axi_r_t   r,
  input logic     r_valid,
  input logic     r_ready,
  input axi_aw_t  aw,
  input logic     aw_valid,
  input logic     aw_ready,
  input axi_w_t   w,
  input logic     w_valid,
  input logic     w_ready,
  input axi_b_t   b,
  input logic     b_valid,
  input logic     b_ready,
  input sram_wr_t wr
);

  int fail_count = 0;

  // A valid that has not been taken holds itself and its payload.
  ar_hold: assert property (@(posedge clk) disable iff (rstn)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
      $error("AR dropped or changed before its transfer");
      fail_count++;
    end

  r_hold: assert property (@(posedge clk) disable iff (rstn)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
      $error("R dropped or changed before its transfer");
      fail_count++;
    end

  aw_hold: assert property (@(posedge clk) disable iff (rstn)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else begin
      $error("AW dropped or changed before its transfer");
      fail_count++;
    end

  w_hold: assert property (@(posedge clk) disable iff (rstn)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else begin
      $error("W dropped or changed before its transfer");
      fail_count++;
    end

  b_hold: assert property (@(posedge clk) disable iff (rstn)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
      $error("B dropped or changed before its transfer");
      fail_count++;
    end

  // One array write per transaction.
  wr_single: assert property (@(posedge clk) disable iff (rstn)
    wr.en |=> !wr.en)
    else begin
      $error("Array write enable high for two cycles in a row");
      fail_count++;
    end

endmodule

bind sram_top sram_properties u_props (
  .clk      (clk),
  .rstn     (rstn),
  .ar       (ar),
  .ar_valid (ar_valid),
  .ar_ready (ar_ready),
  .r        (r),
  .r_valid  (r_valid),
  .r_ready  (r_ready),
  .aw       (aw),
  .aw_valid (aw_valid),
  .aw_ready (aw_ready),
  .w        (w),
  .w_valid  (w_valid),
  .w_ready  (w_ready),
  .b        (b),
  .b_valid  (b_valid),
  .b_ready  (b_ready),
  .wr       (wr)
);

//--- design/sram_top.sv
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_top
  import axi_pkg::*, sram_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  axi_ar_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready,
  input  axi_aw_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready
);

  logic [7:0]              rnd;
  sram_rd_t                rd;
  logic [`SRAM_DATA_W-1:0] rd_data;
  sram_wr_t                wr;

  lfsr8 u_lfsr (
    .clk  (clk),
    .rstn (rstn),
    .seed (8'b1010_1010),
    .rnd  (rnd)
  );

  sram_array u_array (
    .clk     (clk),
    .rd      (rd),
    .rd_data (rd_data),
    .wr      (wr)
  );

  sram_read_channel u_rd (
    .clk      (clk),
    .rstn     (rstn),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .rnd      (rnd),
    .rd       (rd),
    .rd_data  (rd_data)
  );

  sram_write_channel u_wr (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .wr       (wr)
  );

endmodule

//--- design/sram_write_channel.sv
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_write_channel
  import axi_pkg::*, sram_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  axi_aw_t  aw,
  input  logic     aw_valid,
  output logic     aw_ready,
  input  axi_w_t   w,
  input  logic     w_valid,
  output logic     w_ready,
  output axi_b_t   b,
  output logic     b_valid,
  input  logic     b_ready,
  output sram_wr_t wr
);

  localparam int CNT_W = $clog2(`SRAM_WR_LAT + 1);
  localparam int OFF_W = $clog2(`SRAM_STRB_W);

  logic                    have_addr;
  logic                    have_data;
  logic [CNT_W-1:0]        cnt;
  logic [`SRAM_IDX_W-1:0]  idx;
  logic [`SRAM_DATA_W-1:0] data;
  logic [`SRAM_STRB_W-1:0] strb;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;
  logic                    start;
  logic                    done;

  assign aw_ready = ~have_addr;
  assign w_ready  = ~have_data;
  assign aw_fire  = aw_valid & aw_ready;
  assign w_fire   = w_valid & w_ready;
  assign b_fire   = b_valid & b_ready;

  // Both halves present after this edge, with at least one arriving now.
  assign start = (aw_fire | w_fire) & (have_addr | aw_fire) & (have_data | w_fire);

  assign done = have_addr && have_data && (cnt <= CNT_W'(1)) && (!b_valid || b_ready);

  // Write enable lands on the same edge that raises b_valid.
  assign wr = '{en: done, idx: idx, data: data, strb: strb};

  always_ff @(posedge clk) begin
    if (rstn) begin
      have_addr <= 1'b0;
      have_data <= 1'b0;
      cnt       <= '0;
      b_valid   <= 1'b0;
    end else begin
      if (b_fire) begin
        b_valid <= 1'b0;
      end
      if (cnt != '0) begin
        cnt <= cnt - CNT_W'(1);
      end
      if (aw_fire) begin
        have_addr <= 1'b1;
      end
      if (w_fire) begin
        have_data <= 1'b1;
      end
      if (start) begin
        cnt <= CNT_W'(`SRAM_WR_LAT);
      end
      if (done) begin
        have_addr <= 1'b0;
        have_data <= 1'b0;
        b_valid   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      idx <= aw.awaddr[OFF_W +: `SRAM_IDX_W];
    end
    if (w_fire) begin
      data <= w.wdata;
      strb <= w.wstrb;
    end
    if (done) begin
      b.bresp <= RESP_OKAY;
    end
  end

endmodule

//--- design/sram_read_channel.sv
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_read_channel
  import axi_pkg::*, sram_pkg::*;
(
  input  logic                    clk,
  input  logic                    rstn,
  input  axi_ar_t                 ar,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  output axi_r_t                  r,
  output logic                    r_valid,
  input  logic                    r_ready,
  input  logic [7:0]              rnd,
  output sram_rd_t                rd,
  input  logic [`SRAM_DATA_W-1:0] rd_data
);

  // Enough bits for the minimum latency plus the largest LFSR value.
  localparam int CNT_W = $clog2(`SRAM_RD_MIN_LAT + 256);
  localparam int OFF_W = $clog2(`SRAM_STRB_W);

  logic                   busy;
  logic [CNT_W-1:0]       cnt;
  logic [`SRAM_IDX_W-1:0] idx;
  logic                   ar_fire;
  logic                   r_fire;
  logic                   done;

  assign ar_ready = ~busy;
  assign ar_fire  = ar_valid & ar_ready;
  assign r_fire   = r_valid & r_ready;

  // The count reaches 1 on the last waiting cycle; an R still waiting
  // for r_ready holds the new data back.
  assign done = busy && (cnt <= CNT_W'(1)) && (!r_valid || r_ready);

  assign rd.idx = idx;

  always_ff @(posedge clk) begin
    if (rstn) begin
      busy    <= 1'b0;
      cnt     <= '0;
      r_valid <= 1'b0;
    end else begin
      if (r_fire) begin
        r_valid <= 1'b0;
      end
      if (cnt != '0) begin
        cnt <= cnt - CNT_W'(1);
      end
      if (ar_fire) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(rnd) + CNT_W'(`SRAM_RD_MIN_LAT);
      end
      if (done) begin
        busy    <= 1'b0;
        r_valid <= 1'b1;
      end
    end
  end

  // Upper address bits are not decoded.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      idx <= ar.araddr[OFF_W +: `SRAM_IDX_W];
    end
    if (done) begin
      r.rdata <= rd_data;
      r.rresp <= RESP_OKAY;
    end
  end

endmodule

//--- design/sram_array.sv
`timescale 1ns/1ps
`include "sram_macros.svh"

module sram_array
  import sram_pkg::*;
(
  input  logic                    clk,
  input  sram_rd_t                rd,
  output logic [`SRAM_DATA_W-1:0] rd_data,
  input  sram_wr_t                wr
);

  localparam int DEPTH = 1 << `SRAM_IDX_W;
  localparam int BYTE_W = `SRAM_DATA_W / `SRAM_STRB_W;

  logic [`SRAM_DATA_W-1:0] mem [DEPTH];

  assign rd_data = mem[rd.idx];

  // Only the strobed bytes change.
  always_ff @(posedge clk) begin
    if (wr.en) begin
      for (int i = 0; i < `SRAM_STRB_W; i++) begin
        if (wr.strb[i]) begin
          mem[wr.idx][i*BYTE_W +: BYTE_W] <= wr.data[i*BYTE_W +: BYTE_W];
        end
      end
    end
  end

endmodule

//--- design/lfsr8.sv
`timescale 1ns/1ps

module lfsr8 (
  input  logic       clk,
  input  logic       rstn,
  input  logic [7:0] seed,
  output logic [7:0] rnd
);

  logic [7:0] state;
  logic       feedback;

  // Taps 8, 6, 5, 4 give the full 255-state cycle.
  assign feedback = state[7] ^ state[5] ^ state[4] ^ state[3];

  // A zero seed would lock the register at zero.
  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= seed;
    end else begin
      state <= {state[6:0], feedback};
    end
  end

  assign rnd = state;

endmodule

//--- design/sram_pkg.sv
`include "sram_macros.svh"

package sram_pkg;

  // Array read port whose data comes back combinationally.
  typedef struct packed {
    logic [`SRAM_IDX_W-1:0] idx;
  } sram_rd_t;

  // Array write port with one cycle of en per write.
  typedef struct packed {
    logic                    en;
    logic [`SRAM_IDX_W-1:0]  idx;
    logic [`SRAM_DATA_W-1:0] data;
    logic [`SRAM_STRB_W-1:0] strb;
  } sram_wr_t;

endpackage

//--- design/axi_pkg.sv
`include "sram_macros.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // Read address channel.
  typedef struct packed {
    logic [`SRAM_ADDR_W-1:0] araddr;
  } axi_ar_t;

  // Read data channel.
  typedef struct packed {
    logic [`SRAM_DATA_W-1:0] rdata;
    axi_resp_e               rresp;
  } axi_r_t;

  // Write address channel.
  typedef struct packed {
    logic [`SRAM_ADDR_W-1:0] awaddr;
  } axi_aw_t;

  // Write data channel.
  typedef struct packed {
    logic [`SRAM_DATA_W-1:0] wdata;
    logic [`SRAM_STRB_W-1:0] wstrb;
  } axi_w_t;

  // Write response channel.
  typedef struct packed {
    axi_resp_e bresp;
  } axi_b_t;

endpackage

//--- design/sram_macros.svh
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// Byte address and data path widths.
`define SRAM_ADDR_W 32
`define SRAM_DATA_W 32
`define SRAM_STRB_W 4

// Word index width for 256 words.
`define SRAM_IDX_W 8

// Read latency floor; the LFSR adds 0 to 255 on top.
`define SRAM_RD_MIN_LAT 10

// Cycles from the later of AW and W to the array write.
`define SRAM_WR_LAT 2

`endif
